/* hw/i2c_ctrl_pkg.sv */
`default_nettype none

package i2c_ctrl_pkg;

    // ------------------------------------------------------------------------
    // transfer states
    // ------------------------------------------------------------------------
    // the encoding order is significant, since address-done is a
    // magnitude compare against ST_ADDR_ACK
    typedef enum logic [3:0] {
        ST_IDLE         = 4'd0, // bus released, waiting for enable
        ST_START        = 4'd1, // start condition
        ST_ADDR         = 4'd2, // slave address and rw bit
        ST_ADDR_ACK     = 4'd3, // slave acknowledges the address
        ST_WRITE_DATA   = 4'd4, // byte to slave
        ST_READ_DATA    = 4'd5, // byte from slave
        ST_DATA_ACK_IN  = 4'd6, // acknowledge read from slave
        ST_DATA_ACK_OUT = 4'd7, // acknowledge sent by master
        ST_REPEAT_START = 4'd8, // repeated start condition
        ST_STOP         = 4'd9  // stop condition
    } i2c_state_e;

    // ------------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------------
    localparam int unsigned CNT_W = 8; // counters and prescaler

    typedef logic [CNT_W-1:0] cnt_t;

    // ------------------------------------------------------------------------
    // protocol constants
    // ------------------------------------------------------------------------
    localparam cnt_t BYTE_BITS = cnt_t'(8); // datapath bit count at end of byte

    // a start or stop hold runs through 0..HOLD_LAST, four qualifying cycles
    localparam cnt_t HOLD_LAST = cnt_t'(3);

    localparam cnt_t RS_QUARTERS = cnt_t'(4); // prescaler periods per repeated start

endpackage

`default_nettype wire

/* hw/i2c_phase_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_phase_timer (
    input  wire                      i2c_core_clock_i,
    input  wire                      reset_bit_n_i,
    input  wire i2c_ctrl_pkg::i2c_state_e state_i,
    input  wire                      enable_i,
    input  wire i2c_ctrl_pkg::cnt_t  edge_count_i, // clock generator edge count
    input  wire i2c_ctrl_pkg::cnt_t  prescaler_i,
    output logic                     hold_done_o,
    output logic                     rs_done_o,
    output logic                     rs_scl_hold_o
);

    import i2c_ctrl_pkg::*;

    cnt_t hold_cnt;     // start/stop hold
    cnt_t rs_cnt;       // repeated start length
    cnt_t rs_last;      // final repeated start count
    logic hold_state;   // state that runs the hold counter
    logic hold_step;

    // ------------------------------------------------------------------------
    // start/stop hold counter
    // ------------------------------------------------------------------------
    assign hold_state = (state_i == ST_START) || (state_i == ST_STOP) ||
                        ((state_i == ST_IDLE) && enable_i);

    // only counts once the clock generator has passed a full prescaler period
    assign hold_step = (hold_cnt < HOLD_LAST) && (edge_count_i >= prescaler_i) && hold_state;

    assign hold_done_o = (hold_cnt == HOLD_LAST);

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            hold_cnt <= '0;
        end else if (hold_done_o) begin
            hold_cnt <= '0;                      // sequencer leaves on this edge
        end else if (hold_step) begin
            hold_cnt <= hold_cnt + cnt_t'(1);
        end
    end

    // ------------------------------------------------------------------------
    // repeated start timer
    // ------------------------------------------------------------------------
    // the product wraps at CNT_W bits, so prescaler stays at or below 64
    assign rs_last = RS_QUARTERS * prescaler_i - cnt_t'(1);

    assign rs_done_o = (rs_cnt == rs_last);

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            rs_cnt <= '0;
        end else if (rs_done_o) begin
            rs_cnt <= '0;
        end else if (state_i == ST_REPEAT_START) begin
            rs_cnt <= rs_cnt + cnt_t'(1);        // one per core clock
        end
    end

    // scl stays driven for the first quarter so the line is high before sda falls
    assign rs_scl_hold_o = (rs_cnt < prescaler_i);

endmodule

`default_nettype wire

/* hw/i2c_transfer_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_transfer_sequencer (
    input  wire                        i2c_core_clock_i,
    input  wire                        reset_bit_n_i,
    input  wire                        enable_i,
    input  wire                        rw_i,              // 1 = read from slave
    input  wire                        sda_i,
    input  wire                        repeat_start_i,
    input  wire                        tx_fifo_empty_i,
    input  wire                        rx_fifo_full_i,
    input  wire i2c_ctrl_pkg::cnt_t    bit_count_i,       // datapath bit count
    input  wire i2c_ctrl_pkg::cnt_t    edge_count_i,      // clock generator edge count
    input  wire                        hold_done_i,
    input  wire                        rs_done_i,
    output i2c_ctrl_pkg::i2c_state_e   state_o
);

    import i2c_ctrl_pkg::*;

    i2c_state_e state_d;
    i2c_state_e after_ack;  // where a finished data acknowledge goes
    logic       addr_end;   // last address bit shifted
    logic       byte_end;   // last data bit shifted
    logic       ack_end;    // acknowledge slot over

    // ------------------------------------------------------------------------
    // phase end conditions
    // ------------------------------------------------------------------------
    assign addr_end = (bit_count_i == BYTE_BITS) && (edge_count_i == cnt_t'(1));
    assign byte_end = (bit_count_i == BYTE_BITS) && (edge_count_i == '0);
    assign ack_end  = (bit_count_i == '0) && (edge_count_i == '0);

    assign after_ack = repeat_start_i ? ST_REPEAT_START : ST_STOP;

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            state_o <= ST_IDLE;
        end else begin
            state_o <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_o;
        case (state_o)
            ST_IDLE: begin
                if (enable_i && hold_done_i) begin
                    state_d = ST_START;
                end
            end
            ST_START: begin
                if (hold_done_i) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (addr_end) begin
                    state_d = ST_ADDR_ACK;
                end
            end
            ST_ADDR_ACK: begin
                if (ack_end) begin
                    if (sda_i) begin
                        state_d = ST_STOP;                            // nack on address
                    end else if (rw_i) begin
                        state_d = rx_fifo_full_i ? ST_STOP : ST_READ_DATA;
                    end else begin
                        state_d = tx_fifo_empty_i ? ST_STOP : ST_WRITE_DATA;
                    end
                end
            end
            ST_WRITE_DATA: begin
                if (byte_end) begin
                    state_d = ST_DATA_ACK_IN;
                end
            end
            ST_READ_DATA: begin
                if (byte_end) begin
                    state_d = ST_DATA_ACK_OUT;
                end
            end
            ST_DATA_ACK_IN: begin
                if (ack_end) begin
                    // nothing left to send, or the slave refused the byte
                    state_d = (tx_fifo_empty_i || sda_i) ? after_ack : ST_WRITE_DATA;
                end
            end
            ST_DATA_ACK_OUT: begin
                if (ack_end) begin
                    state_d = rx_fifo_full_i ? after_ack : ST_READ_DATA;
                end
            end
            ST_REPEAT_START: begin
                if (rs_done_i) begin
                    state_d = ST_ADDR;                                // resend address
                end
            end
            ST_STOP: begin
                if (hold_done_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/i2c_bus_ctrl_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_bus_ctrl_decoder (
    input  wire                           i2c_core_clock_i,
    input  wire                           reset_bit_n_i,
    input  wire i2c_ctrl_pkg::i2c_state_e state_i,
    input  wire                           rs_scl_hold_i,  // first quarter of repeated start
    output logic                          start_o,
    output logic                          write_addr_o,
    output logic                          write_data_o,
    output logic                          read_data_o,
    output logic                          write_ack_o,    // master drives ack
    output logic                          read_ack_o,     // master samples ack
    output logic                          stop_o,
    output logic                          repeat_start_o,
    output logic                          tx_fifo_rd_o,
    output logic                          rx_fifo_wr_o,
    output logic                          scl_en_o,
    output logic                          sda_en_o,
    output logic                          bus_free_o,
    output logic                          addr_done_o
);

    import i2c_ctrl_pkg::*;

    i2c_state_e prev_state; // state one cycle earlier

    // ------------------------------------------------------------------------
    // phase strobes and line enables
    // ------------------------------------------------------------------------
    assign start_o        = (state_i == ST_START);
    assign write_addr_o   = (state_i == ST_ADDR);
    assign write_data_o   = (state_i == ST_WRITE_DATA);
    assign read_data_o    = (state_i == ST_READ_DATA);
    assign write_ack_o    = (state_i == ST_DATA_ACK_OUT);
    assign read_ack_o     = (state_i == ST_ADDR_ACK) || (state_i == ST_DATA_ACK_IN);
    assign stop_o         = (state_i == ST_STOP);
    assign repeat_start_o = (state_i == ST_REPEAT_START);
    assign bus_free_o     = (state_i == ST_IDLE);

    always_comb begin
        sda_en_o = 1'b0;
        scl_en_o = 1'b0;
        case (state_i)
            ST_START: begin
                sda_en_o = 1'b1;                 // scl left high by clock gen
            end
            ST_ADDR, ST_WRITE_DATA, ST_DATA_ACK_OUT, ST_STOP: begin
                sda_en_o = 1'b1;
                scl_en_o = 1'b1;
            end
            ST_ADDR_ACK, ST_READ_DATA, ST_DATA_ACK_IN: begin
                scl_en_o = 1'b1;                 // slave owns sda
            end
            ST_REPEAT_START: begin
                sda_en_o = 1'b1;
                scl_en_o = rs_scl_hold_i;
            end
            default: begin
                sda_en_o = 1'b0;
                scl_en_o = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // fifo strobes and address flag
    // ------------------------------------------------------------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            prev_state  <= ST_IDLE;
            addr_done_o <= 1'b0;
        end else begin
            prev_state  <= state_i;
            addr_done_o <= (state_i >= ST_ADDR_ACK);
        end
    end

    // high only on the first cycle after the byte phase hands over
    assign tx_fifo_rd_o = (state_i == ST_DATA_ACK_IN) && (prev_state == ST_WRITE_DATA);
    assign rx_fifo_wr_o = (state_i == ST_DATA_ACK_OUT) && (prev_state == ST_READ_DATA);

endmodule

`default_nettype wire

/* hw/i2c_master_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_master_ctrl (
    input  wire                       i2c_core_clock_i,
    input  wire                       reset_bit_n_i,
    input  wire                       enable_i,
    input  wire                       rw_i,
    input  wire                       sda_i,
    input  wire                       repeat_start_i,
    input  wire                       tx_fifo_empty_i,
    input  wire                       rx_fifo_full_i,
    input  wire i2c_ctrl_pkg::cnt_t   edge_count_i,
    input  wire i2c_ctrl_pkg::cnt_t   bit_count_i,
    input  wire i2c_ctrl_pkg::cnt_t   prescaler_i,
    output logic                      start_o,
    output logic                      write_addr_o,
    output logic                      write_data_o,
    output logic                      read_data_o,
    output logic                      write_ack_o,
    output logic                      read_ack_o,
    output logic                      stop_o,
    output logic                      repeat_start_o,
    output logic                      tx_fifo_rd_o,
    output logic                      rx_fifo_wr_o,
    output logic                      scl_en_o,
    output logic                      sda_en_o,
    output logic                      bus_free_o,
    output logic                      addr_done_o
);

    import i2c_ctrl_pkg::*;

    i2c_state_e state;
    logic       hold_done;
    logic       rs_done;
    logic       rs_scl_hold;

    // ------------------------------------------------------------------------
    // phase timer and sequencer close a loop through state and done flags
    // ------------------------------------------------------------------------
    i2c_phase_timer u_timer (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .state_i          (state),
        .enable_i         (enable_i),
        .edge_count_i     (edge_count_i),
        .prescaler_i      (prescaler_i),
        .hold_done_o      (hold_done),
        .rs_done_o        (rs_done),
        .rs_scl_hold_o    (rs_scl_hold)
    );

    i2c_transfer_sequencer u_sequencer (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .enable_i         (enable_i),
        .rw_i             (rw_i),
        .sda_i            (sda_i),
        .repeat_start_i   (repeat_start_i),
        .tx_fifo_empty_i  (tx_fifo_empty_i),
        .rx_fifo_full_i   (rx_fifo_full_i),
        .bit_count_i      (bit_count_i),
        .edge_count_i     (edge_count_i),
        .hold_done_i      (hold_done),
        .rs_done_i        (rs_done),
        .state_o          (state)
    );

    i2c_bus_ctrl_decoder u_decoder (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .state_i          (state),
        .rs_scl_hold_i    (rs_scl_hold),
        .start_o          (start_o),
        .write_addr_o     (write_addr_o),
        .write_data_o     (write_data_o),
        .read_data_o      (read_data_o),
        .write_ack_o      (write_ack_o),
        .read_ack_o       (read_ack_o),
        .stop_o           (stop_o),
        .repeat_start_o   (repeat_start_o),
        .tx_fifo_rd_o     (tx_fifo_rd_o),
        .rx_fifo_wr_o     (rx_fifo_wr_o),
        .scl_en_o         (scl_en_o),
        .sda_en_o         (sda_en_o),
        .bus_free_o       (bus_free_o),
        .addr_done_o      (addr_done_o)
    );

endmodule

`default_nettype wire

/* dv/i2c_master_ctrl_props.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_master_ctrl_props (
    input wire       i2c_core_clock_i,
    input wire       reset_bit_n_i,
    input wire [7:0] phase_i,       // start .. repeat_start strobes
    input wire       tx_fifo_rd_i,
    input wire       rx_fifo_wr_i,
    input wire       scl_en_i,
    input wire       sda_en_i,
    input wire       bus_free_i
);

    int unsigned fail_count = 0;    // failed assertion count

    // ------------------------------------------------------------------------
    // decoder output rules
    // ------------------------------------------------------------------------
    phase_onehot: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        $onehot0(phase_i))
    else begin
        $error("more than one phase strobe high");
        fail_count++;
    end

    fifo_exclusive: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        !(tx_fifo_rd_i && rx_fifo_wr_i))
    else begin
        $error("both fifo strobes high");
        fail_count++;
    end

    free_released: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        bus_free_i |-> (!scl_en_i && !sda_en_i))
    else begin
        $error("line enable high while bus free");
        fail_count++;
    end

    tx_single: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        tx_fifo_rd_i |=> !tx_fifo_rd_i)
    else begin
        $error("tx fifo read strobe wider than one cycle");
        fail_count++;
    end

    rx_single: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        rx_fifo_wr_i |=> !rx_fifo_wr_i)
    else begin
        $error("rx fifo write strobe wider than one cycle");
        fail_count++;
    end

endmodule

bind i2c_bus_ctrl_decoder i2c_master_ctrl_props u_props (
    .i2c_core_clock_i (i2c_core_clock_i),
    .reset_bit_n_i    (reset_bit_n_i),
    .phase_i          ({start_o, write_addr_o, write_data_o, read_data_o,
                        write_ack_o, read_ack_o, stop_o, repeat_start_o}),
    .tx_fifo_rd_i     (tx_fifo_rd_o),
    .rx_fifo_wr_i     (rx_fifo_wr_o),
    .scl_en_i         (scl_en_o),
    .sda_en_i         (sda_en_o),
    .bus_free_i       (bus_free_o)
);

`default_nettype wire

/* dv/i2c_master_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_master_ctrl_tb;

    import i2c_ctrl_pkg::*;

    localparam int   PERIOD = 100;
    localparam cnt_t PS     = cnt_t'(2);     // 4 x PS cycles of repeated start

    // expected strobe vector, DUT port order with addr_done in bit 0
    localparam logic [9:0] P_START = 10'b10_0000_0000;
    localparam logic [9:0] P_ADDR  = 10'b01_0000_0000;
    localparam logic [9:0] P_WDATA = 10'b00_1000_0000;
    localparam logic [9:0] P_RDATA = 10'b00_0100_0000;
    localparam logic [9:0] P_WACK  = 10'b00_0010_0000;
    localparam logic [9:0] P_RACK  = 10'b00_0001_0000;
    localparam logic [9:0] P_STOP  = 10'b00_0000_1000;
    localparam logic [9:0] P_RS    = 10'b00_0000_0100;
    localparam logic [9:0] P_IDLE  = 10'b00_0000_0010;
    localparam logic [9:0] AD      = 10'b00_0000_0001;

    typedef struct packed {
        logic [5:0] flags;      // enable rw sda repeat_start tx_empty rx_full
        cnt_t       edge_cnt;
        cnt_t       bit_cnt;
        cnt_t       presc;
        logic [7:0] hold;       // cycles, sampled in the last one
        logic [9:0] strobes;
        logic [3:0] lines;      // scl_en sda_en tx_fifo_rd rx_fifo_wr
    } row_t;

    logic i2c_core_clock_i;
    logic reset_bit_n_i;
    logic enable_i, rw_i, sda_i, repeat_start_i, tx_fifo_empty_i, rx_fifo_full_i;
    cnt_t edge_count_i, bit_count_i, prescaler_i;
    logic start_o, write_addr_o, write_data_o, read_data_o, write_ack_o, read_ack_o;
    logic stop_o, repeat_start_o, tx_fifo_rd_o, rx_fifo_wr_o;
    logic scl_en_o, sda_en_o, bus_free_o, addr_done_o;

    row_t        rows[$];
    logic        table_ready = 1'b0;

    i2c_master_ctrl UUT (.*);

    initial begin
        i2c_core_clock_i = 1'b0;
        forever #(PERIOD / 2) i2c_core_clock_i = ~i2c_core_clock_i;
    end

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(negedge i2c_core_clock_i) begin
        if (UUT.u_decoder.u_props.fail_count != 0) begin
            $display("a bound assertion on the decoder outputs failed");
            $display("Regression failed");
            $fatal(1, "assertion failure");
        end
    end

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic add_row(input logic [5:0] flags, input cnt_t edge_cnt, input cnt_t bit_cnt,
                           input cnt_t presc, input int hold, input logic [9:0] strobes,
                           input logic [3:0] lines);
        row_t r;
        r.flags    = flags;
        r.edge_cnt = edge_cnt;
        r.bit_cnt  = bit_cnt;
        r.presc    = presc;
        r.hold     = hold[7:0];
        r.strobes  = strobes;
        r.lines    = lines;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(6'b000000, 8'd0, 8'd0, PS, 1, P_IDLE, 4'b0000);       // after reset
        add_row(6'b100000, 8'd2, 8'd0, PS, 4, P_IDLE, 4'b0000);       // idle hold
        add_row(6'b100000, 8'd2, 8'd0, PS, 1, P_START, 4'b0100);
        add_row(6'b100000, 8'd2, 8'd0, PS, 3, P_START, 4'b0100);
        add_row(6'b100000, 8'd2, 8'd0, PS, 1, P_ADDR, 4'b1100);
        add_row(6'b100000, 8'd1, 8'd8, PS, 2, P_RACK, 4'b1000);       // address done
        add_row(6'b100000, 8'd0, 8'd0, PS, 2, P_WDATA | AD, 4'b1100); // ack, write
        add_row(6'b100000, 8'd0, 8'd8, PS, 2, P_RACK | AD, 4'b1010);
        add_row(6'b100000, 8'd3, 8'd5, PS, 1, P_RACK | AD, 4'b1000);
        add_row(6'b100000, 8'd0, 8'd0, PS, 2, P_WDATA | AD, 4'b1100); // next byte
        add_row(6'b100000, 8'd0, 8'd8, PS, 2, P_RACK | AD, 4'b1010);
        add_row(6'b100110, 8'd0, 8'd0, PS, 1, P_RACK | AD, 4'b1000);  // tx empty, restart
        add_row(6'b100110, 8'd3, 8'd5, PS, 2, P_RS | AD, 4'b1100);
        add_row(6'b100110, 8'd3, 8'd5, PS, 1, P_RS | AD, 4'b0100);
        add_row(6'b100110, 8'd3, 8'd5, PS, 5, P_RS | AD, 4'b0100);
        add_row(6'b100110, 8'd3, 8'd5, PS, 1, P_ADDR | AD, 4'b1100);
        add_row(6'b110000, 8'd1, 8'd8, PS, 2, P_RACK, 4'b1000);       // read transfer
        add_row(6'b110000, 8'd0, 8'd0, PS, 2, P_RDATA | AD, 4'b1000);
        add_row(6'b110000, 8'd0, 8'd8, PS, 2, P_WACK | AD, 4'b1101);
        add_row(6'b110000, 8'd3, 8'd5, PS, 1, P_WACK | AD, 4'b1100);
        add_row(6'b110000, 8'd0, 8'd0, PS, 2, P_RDATA | AD, 4'b1000);
        add_row(6'b110000, 8'd0, 8'd8, PS, 2, P_WACK | AD, 4'b1101);
        add_row(6'b110001, 8'd0, 8'd0, PS, 1, P_WACK | AD, 4'b1100);  // rx full
        add_row(6'b010001, 8'd2, 8'd0, PS, 1, P_STOP | AD, 4'b1100);
        add_row(6'b010001, 8'd2, 8'd0, PS, 3, P_STOP | AD, 4'b1100);
        add_row(6'b010001, 8'd2, 8'd0, PS, 1, P_IDLE | AD, 4'b0000);
        add_row(6'b010001, 8'd2, 8'd0, PS, 1, P_IDLE, 4'b0000);
        add_row(6'b100000, 8'd2, 8'd0, PS, 9, P_ADDR, 4'b1100);       // no acknowledge
        add_row(6'b100000, 8'd1, 8'd8, PS, 2, P_RACK, 4'b1000);
        add_row(6'b101000, 8'd0, 8'd0, PS, 2, P_STOP | AD, 4'b1100);
        add_row(6'b001000, 8'd2, 8'd0, PS, 5, P_IDLE | AD, 4'b0000);
        add_row(6'b000000, 8'd0, 8'd0, PS, 1, P_IDLE, 4'b0000);
    endtask

    task automatic apply_row(input int idx, input row_t r);
        @(posedge i2c_core_clock_i);
        enable_i        <= r.flags[5];
        rw_i            <= r.flags[4];
        sda_i           <= r.flags[3];
        repeat_start_i  <= r.flags[2];
        tx_fifo_empty_i <= r.flags[1];
        rx_fifo_full_i  <= r.flags[0];
        edge_count_i    <= r.edge_cnt;
        bit_count_i     <= r.bit_cnt;
        prescaler_i     <= r.presc;
        repeat (r.hold) @(negedge i2c_core_clock_i);
        check_value($sformatf("row %0d phase strobes", idx), r.strobes,
                    {start_o, write_addr_o, write_data_o, read_data_o, write_ack_o,
                     read_ack_o, stop_o, repeat_start_o, bus_free_o, addr_done_o});
        check_value($sformatf("row %0d scl_en sda_en tx_fifo_rd rx_fifo_wr", idx), r.lines,
                    {scl_en_o, sda_en_o, tx_fifo_rd_o, rx_fifo_wr_o});
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        reset_bit_n_i   = 1'b0;
        enable_i        = 1'b0;
        rw_i            = 1'b0;
        sda_i           = 1'b0;
        repeat_start_i  = 1'b0;
        tx_fifo_empty_i = 1'b0;
        rx_fifo_full_i  = 1'b0;
        edge_count_i    = '0;
        bit_count_i     = '0;
        prescaler_i     = PS;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge i2c_core_clock_i);
        reset_bit_n_i <= 1'b1;
        foreach (rows[i]) begin
            apply_row(i, rows[i]);
        end
        if (UUT.u_decoder.u_props.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        int unsigned total;
        total = 20;                     // reset and margin
        wait (table_ready);
        foreach (rows[i]) begin
            total += rows[i].hold;
        end
        #(total * PERIOD);
        $display("timeout: the test sequence did not complete in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* compile.f */
hw/i2c_ctrl_pkg.sv
hw/i2c_phase_timer.sv
hw/i2c_transfer_sequencer.sv
hw/i2c_bus_ctrl_decoder.sv
hw/i2c_master_ctrl.sv
dv/i2c_master_ctrl_props.sv
dv/i2c_master_ctrl_tb.sv

/* Bender.yml */
package:
  name: i2c_master_ctrl

sources:
  - hw/i2c_ctrl_pkg.sv
  - hw/i2c_phase_timer.sv
  - hw/i2c_transfer_sequencer.sv
  - hw/i2c_bus_ctrl_decoder.sv
  - hw/i2c_master_ctrl.sv
  - target: simulation
    files:
      - dv/i2c_master_ctrl_props.sv
      - dv/i2c_master_ctrl_tb.sv
